/* source/preDecodePkg.sv */
`default_nettype none

package preDecodePkg;

    // one 32-byte fetch line
    localparam int FETCH_WIDTH  = 8;
    localparam int OFFSET_WIDTH = 26;

    typedef logic [31:0]             addrT;
    typedef logic [31:0]             instT;
    typedef logic [2:0]              slotIdxT;
    typedef logic [OFFSET_WIDTH-1:0] offsetT;

    typedef enum logic [2:0] {
        CLS_PLAIN  = 3'd0,
        CLS_DIRECT = 3'd1,
        CLS_BRANCH = 3'd2,
        CLS_CALL   = 3'd3,
        CLS_RETURN = 3'd4
    } instClassT;

    // major opcodes, bits 31:26
    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BNE  = 6'b010111;
    localparam logic [5:0] OP_BLT  = 6'b011000;
    localparam logic [5:0] OP_BGE  = 6'b011001;
    localparam logic [5:0] OP_BLTU = 6'b011010;
    localparam logic [5:0] OP_BGEU = 6'b011011;

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;

    typedef struct packed {
        addrT                   basePc;
        instT [FETCH_WIDTH-1:0] inst;
        logic [FETCH_WIDTH-1:0] valid;
    } fetchBundleT;

    typedef struct packed {
        logic      btbValid;
        instClassT btbClass;
        addrT      btbTarget;
        logic      rasValid;
        addrT      rasTarget;
        logic      tageValid;
        logic      tageTaken;
    } predictT;

    typedef struct packed {
        logic      redirectValid;
        addrT      redirectPc;
        logic      btbUpdValid;
        addrT      btbUpdPc;
        logic      btbUpdClassValid;
        instClassT btbUpdClass;
        logic      btbUpdTargetValid;
        addrT      btbUpdTarget;
    } redirectT;

    typedef struct packed {
        logic valid;
        logic predTaken;
        addrT pc;
        addrT target;
        instT inst;
    } ibEntryT;

    typedef ibEntryT [FETCH_WIDTH-1:0] ibBundleT;

endpackage

`default_nettype wire

/* source/instClassify.sv */
`default_nettype none

module instClassify
    import preDecodePkg::*;
(
    input  instT      inst,
    output instClassT instClass,
    output offsetT    offset
);

    logic [5:0] opcode;
    logic [4:0] rd;
    logic [4:0] rj;

    assign opcode = inst[31:26];
    assign rd     = inst[4:0];
    assign rj     = inst[9:5];

    always_comb begin
        instClass = CLS_PLAIN;
        case (opcode)
            OP_JIRL: begin
                // link to ra is a call, jump through ra is a return
                if (rd == REG_RA) begin
                    instClass = CLS_CALL;
                end else if (rd == REG_ZERO && rj == REG_RA) begin
                    instClass = CLS_RETURN;
                end
            end
            OP_B, OP_BL: instClass = CLS_DIRECT;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: instClass = CLS_BRANCH;
            default: instClass = CLS_PLAIN;
        endcase
    end

    // high part of the offset sits in the low ten bits
    assign offset = {inst[9:0], inst[25:10]};

endmodule

`default_nettype wire

/* source/endSlotLocate.sv */
`default_nettype none

module endSlotLocate
    import preDecodePkg::*;
(
    input  fetchBundleT fetch,
    input  instClassT   slotClass [FETCH_WIDTH],
    input  offsetT      slotOffset [FETCH_WIDTH],
    output slotIdxT     endIdx,
    output addrT        endPc,
    output instClassT   endClass,
    output offsetT      endOffset
);

    // first control-flow or invalid slot, last slot otherwise
    always_comb begin
        endIdx = slotIdxT'(FETCH_WIDTH - 1);
        for (int i = FETCH_WIDTH - 2; i >= 0; i--) begin
            if (slotClass[i] != CLS_PLAIN || !fetch.valid[i]) begin
                endIdx = slotIdxT'(i);
            end
        end
    end

    // slots are word aligned from the base pc
    assign endPc     = fetch.basePc + (addrT'(endIdx) << 2);
    assign endClass  = slotClass[endIdx];
    assign endOffset = slotOffset[endIdx];

endmodule

`default_nettype wire

/* source/targetCheck.sv */
`default_nettype none

module targetCheck
    import preDecodePkg::*;
(
    input  predictT   predict,
    input  slotIdxT   endIdx,
    input  addrT      endPc,
    input  instClassT endClass,
    input  offsetT    endOffset,
    output addrT      finalTarget,
    output logic      anyTargetFault,
    output redirectT  redirectOut
);

    addrT jumpTarget;
    addrT branchTarget;
    addrT seqTarget;
    addrT lineTarget;
    addrT impliedTarget;
    logic checkEn;
    logic targetFault;
    logic classFault;

    assign jumpTarget   = endPc + addrT'(endOffset);
    assign branchTarget = endPc + addrT'(endOffset[15:0]);
    assign seqTarget    = endPc + 32'd4;
    // plain bundle falls through to the next fetch line
    assign lineTarget   = {endPc[31:5], 5'd0} + 32'd32;

    always_comb begin
        impliedTarget = '0;
        checkEn       = 1'b0;
        case (endClass)
            CLS_DIRECT: begin
                impliedTarget = jumpTarget;
                checkEn       = 1'b1;
            end
            CLS_RETURN: begin
                impliedTarget = predict.rasTarget;
                checkEn       = predict.rasValid;
            end
            CLS_BRANCH: begin
                impliedTarget = predict.tageTaken ? branchTarget : seqTarget;
                checkEn       = predict.tageValid;
            end
            CLS_PLAIN: begin
                impliedTarget = lineTarget;
                checkEn       = 1'b1;
            end
            // calls are left to the btb
            default: begin
                impliedTarget = '0;
                checkEn       = 1'b0;
            end
        endcase
    end

    assign targetFault = predict.btbValid && checkEn && (impliedTarget != predict.btbTarget);
    assign classFault  = predict.btbValid && (predict.btbClass != endClass);

    assign anyTargetFault = targetFault;
    assign finalTarget    = targetFault ? impliedTarget : predict.btbTarget;

    always_comb begin
        redirectOut.redirectValid     = targetFault;
        redirectOut.redirectPc        = targetFault ? impliedTarget : '0;
        redirectOut.btbUpdValid       = targetFault || classFault;
        // btb is indexed by the bundle base
        redirectOut.btbUpdPc          = endPc - (addrT'(endIdx) << 2);
        redirectOut.btbUpdClassValid  = classFault;
        redirectOut.btbUpdClass       = endClass;
        redirectOut.btbUpdTargetValid = targetFault;
        redirectOut.btbUpdTarget      = targetFault ? impliedTarget : '0;
    end

endmodule

`default_nettype wire

/* source/bundleEmit.sv */
`default_nettype none

module bundleEmit
    import preDecodePkg::*;
(
    input  fetchBundleT fetch,
    input  instClassT   slotClass [FETCH_WIDTH],
    input  predictT     predict,
    input  slotIdxT     endIdx,
    input  addrT        finalTarget,
    output ibBundleT    ibBundle
);

    logic predTakenCtrl;

    assign predTakenCtrl = predict.tageTaken && predict.tageValid;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            // the end slot itself is still handed on
            ibBundle[i].valid = (i <= int'(endIdx));
            ibBundle[i].pc    = fetch.basePc + addrT'(4 * i);
            ibBundle[i].inst  = fetch.inst[i];
            if (slotClass[i] != CLS_PLAIN) begin
                ibBundle[i].predTaken = predTakenCtrl;
                ibBundle[i].target    = finalTarget;
            end else begin
                ibBundle[i].predTaken = 1'b1;
                ibBundle[i].target    = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/stageReg.sv */
`default_nettype none

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    Clk,
    input  logic    arstN,
    input  logic    flush,
    input  logic    stop,
    input  payloadT d,
    output payloadT q
);

    payloadT stateQ;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            stateQ <= '0;
        end else if (flush) begin
            stateQ <= '0;
        end else begin
            stateQ <= d;
        end
    end

    // keeps loading under stop, only the view is blanked
    assign q = stop ? payloadT'('0) : stateQ;

endmodule

`default_nettype wire

/* source/preDecodeTop.sv */
`default_nettype none

module preDecodeTop
    import preDecodePkg::*;
(
    input  logic        Clk,
    input  logic        arstN,
    input  logic        flush,
    input  logic        stop,
    input  fetchBundleT fetch,
    input  predictT     predict,
    output redirectT    redirect,
    output ibBundleT    ibOut
);

    instClassT slotClass [FETCH_WIDTH];
    offsetT    slotOffset [FETCH_WIDTH];
    slotIdxT   endIdx;
    addrT      endPc;
    instClassT endClass;
    offsetT    endOffset;
    addrT      finalTarget;
    redirectT  redirectD;
    ibBundleT  ibD;

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : gClassify
        instClassify uClassify (
            .inst      (fetch.inst[i]),
            .instClass (slotClass[i]),
            .offset    (slotOffset[i])
        );
    end

    endSlotLocate uEndSlot (
        .fetch      (fetch),
        .slotClass  (slotClass),
        .slotOffset (slotOffset),
        .endIdx     (endIdx),
        .endPc      (endPc),
        .endClass   (endClass),
        .endOffset  (endOffset)
    );

    // fault flag already folded into finalTarget
    targetCheck uTargetCheck (
        .predict        (predict),
        .endIdx         (endIdx),
        .endPc          (endPc),
        .endClass       (endClass),
        .endOffset      (endOffset),
        .finalTarget    (finalTarget),
        .anyTargetFault (),
        .redirectOut    (redirectD)
    );

    bundleEmit uBundleEmit (
        .fetch       (fetch),
        .slotClass   (slotClass),
        .predict     (predict),
        .endIdx      (endIdx),
        .finalTarget (finalTarget),
        .ibBundle    (ibD)
    );

    stageReg #(
        .payloadT (redirectT)
    ) uRedirectReg (
        .Clk   (Clk),
        .arstN (arstN),
        .flush (flush),
        .stop  (stop),
        .d     (redirectD),
        .q     (redirect)
    );

    stageReg #(
        .payloadT (ibBundleT)
    ) uIbReg (
        .Clk   (Clk),
        .arstN (arstN),
        .flush (flush),
        .stop  (stop),
        .d     (ibD),
        .q     (ibOut)
    );

endmodule

`default_nettype wire

/* verif/preDecodeCheck.sv */
`default_nettype none

module preDecodeCheck
    import preDecodePkg::*;
(
    input  logic       Clk,
    input  logic       sampleEn,
    input  int         testNum,
    input  redirectT   redirect,
    input  ibBundleT   ibOut,
    input  addrT       basePc,
    input  logic       expRedirValid,
    input  addrT       expRedirPc,
    input  logic       expUpdValid,
    input  logic       expUpdClassValid,
    input  logic       expUpdTargetValid,
    input  logic [7:0] expMask,
    input  addrT       expTarget,
    output int         passCount,
    output int         failCount
);

    int         passTotal = 0;
    int         failTotal = 0;
    int         testErrors;
    int         endSlot;
    logic [7:0] gotMask;
    addrT       wantUpdPc;

    assign passCount = passTotal;
    assign failCount = failTotal;

    // end slot is the highest valid entry
    function automatic int lastSlot(input logic [7:0] mask);
        int idx;
        idx = 0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (mask[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got == want) else begin
            $display("ERROR at time %0t: test %0d, %s is %0h, expected %0h",
                     $time, testNum, name, got, want);
            testErrors++;
        end
    endtask

    // outputs settle after the edge, next stimulus arrives at +10
    always @(posedge Clk) begin
        #5;
        if (sampleEn) begin
            testErrors = 0;
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                gotMask[i] = ibOut[i].valid;
            end
            endSlot = lastSlot(expMask);
            // entry 0 is valid in every bundle that is not blanked
            wantUpdPc = (expMask == 8'h00) ? 32'd0 : basePc;
            compareField("redirectValid", 32'(redirect.redirectValid), 32'(expRedirValid));
            compareField("redirectPc", redirect.redirectPc, expRedirPc);
            compareField("btbUpdValid", 32'(redirect.btbUpdValid), 32'(expUpdValid));
            compareField("btbUpdPc", redirect.btbUpdPc, wantUpdPc);
            compareField("btbUpdClassValid", 32'(redirect.btbUpdClassValid),
                         32'(expUpdClassValid));
            compareField("btbUpdTargetValid", 32'(redirect.btbUpdTargetValid),
                         32'(expUpdTargetValid));
            // update target follows the redirect pc
            compareField("btbUpdTarget", redirect.btbUpdTarget, expRedirPc);
            compareField("ibOut valid mask", 32'(gotMask), 32'(expMask));
            compareField("end-slot target", ibOut[endSlot].target, expTarget);
            if (testErrors == 0) begin
                passTotal++;
                $display("test %0d: ok", testNum);
            end else begin
                failTotal++;
                $display("test %0d: %0d field(s) wrong", testNum, testErrors);
            end
        end
    end

endmodule

`default_nettype wire

/* verif/preDecodeTb.sv */
`default_nettype none

module preDecodeTb
    import preDecodePkg::*;
();

    // one line of the test data file
    typedef struct packed {
        logic        flush;
        logic        stop;
        fetchBundleT fetch;
        predictT     predict;
        logic        expRedirValid;
        addrT        expRedirPc;
        logic        expUpdValid;
        logic        expUpdClassValid;
        logic        expUpdTargetValid;
        logic [7:0]  expMask;
        addrT        expTarget;
    } testLineT;

    logic        Clk = 1'b0;
    logic        arstN;
    logic        flush;
    logic        stop;
    fetchBundleT fetch;
    predictT     predict;
    redirectT    redirect;
    ibBundleT    ibOut;
    logic        sampleEn;
    int          testNum;
    testLineT    cur;
    testLineT    tests [$];
    logic        loaded = 1'b0;
    int          parseErrors = 0;
    int          passCount;
    int          failCount;

    always #50 Clk = ~Clk;

    preDecodeTop dut0 (
        .Clk      (Clk),
        .arstN    (arstN),
        .flush    (flush),
        .stop     (stop),
        .fetch    (fetch),
        .predict  (predict),
        .redirect (redirect),
        .ibOut    (ibOut)
    );

    preDecodeCheck check0 (
        .Clk               (Clk),
        .sampleEn          (sampleEn),
        .testNum           (testNum),
        .redirect          (redirect),
        .ibOut             (ibOut),
        .basePc            (cur.fetch.basePc),
        .expRedirValid     (cur.expRedirValid),
        .expRedirPc        (cur.expRedirPc),
        .expUpdValid       (cur.expUpdValid),
        .expUpdClassValid  (cur.expUpdClassValid),
        .expUpdTargetValid (cur.expUpdTargetValid),
        .expMask           (cur.expMask),
        .expTarget         (cur.expTarget),
        .passCount         (passCount),
        .failCount         (failCount)
    );

    task automatic readTests();
        int          fd;
        int          n;
        string       text;
        logic [31:0] col [26];
        testLineT    t;
        fd = $fopen("verif/preDecodeTestdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            parseErrors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(text, fd);
            if (n < 2 || text.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
                col[17], col[18], col[19], col[20], col[21], col[22], col[23], col[24],
                col[25]);
            if (n != 26) begin
                $display("malformed line in the test data file: %s", text);
                parseErrors++;
                continue;
            end
            t.flush        = col[0][0];
            t.stop         = col[1][0];
            t.fetch.basePc = col[2];
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                t.fetch.inst[i] = col[3 + i];
            end
            t.fetch.valid         = col[11][7:0];
            t.predict.btbValid    = col[12][0];
            t.predict.btbClass    = instClassT'(col[13][2:0]);
            t.predict.btbTarget   = col[14];
            t.predict.rasValid    = col[15][0];
            t.predict.rasTarget   = col[16];
            t.predict.tageValid   = col[17][0];
            t.predict.tageTaken   = col[18][0];
            t.expRedirValid       = col[19][0];
            t.expRedirPc          = col[20];
            t.expUpdValid         = col[21][0];
            t.expUpdClassValid    = col[22][0];
            t.expUpdTargetValid   = col[23][0];
            t.expMask             = col[24][7:0];
            t.expTarget           = col[25];
            tests.push_back(t);
        end
        $fclose(fd);
    endtask

    // watchdog sized from the number of tests
    initial begin
        wait (loaded);
        #((tests.size() + 10) * 100);
        $display("timeout: the run did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        arstN    = 1'b0;
        flush    = 1'b0;
        stop     = 1'b0;
        fetch    = '0;
        predict  = '0;
        sampleEn = 1'b0;
        testNum  = 0;
        cur      = '0;
        readTests();
        loaded = 1'b1;
        repeat (3) @(posedge Clk);
        #10;
        // test 0 expects all-zero outputs while reset is held
        sampleEn = 1'b1;
        @(posedge Clk);
        #10;
        arstN = 1'b1;
        foreach (tests[k]) begin
            cur     = tests[k];
            flush   = tests[k].flush;
            stop    = tests[k].stop;
            fetch   = tests[k].fetch;
            predict = tests[k].predict;
            testNum = k + 1;
            @(posedge Clk);
            #10;
        end
        sampleEn = 1'b0;
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0 && parseErrors == 0 && tests.size() > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/preDecodeTestdata.txt */
# flush stop basePc inst0..inst7 validMask btbValid btbClass btbTarget rasValid rasTarget tageValid tageTaken
# expected: redirValid redirPc btbUpdValid btbUpdClassValid btbUpdTargetValid ibValidMask endTarget
# classes: 0 plain, 1 direct, 2 branch, 3 call, 4 return
0 0 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 0 00002000 0 00000000 0 0 1 00001020 1 0 1 ff 00000000
0 0 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 0 00001020 0 00000000 0 0 0 00000000 0 0 0 ff 00000000
0 0 00001000 02800000 02800000 02800000 50010000 02800000 02800000 02800000 02800000 ff 1 2 00003000 0 00000000 0 0 1 0000104c 1 1 1 0f 0000104c
0 0 00002000 02800000 02800000 58008000 02800000 02800000 02800000 02800000 02800000 ff 1 2 00002100 0 00000000 1 1 1 00002028 1 0 1 07 00002028
0 0 00002000 02800000 02800000 58008000 02800000 02800000 02800000 02800000 02800000 ff 1 2 00002100 0 00000000 1 0 1 0000200c 1 0 1 07 0000200c
0 0 00002000 02800000 02800000 58008000 02800000 02800000 02800000 02800000 02800000 ff 1 2 00002028 0 00000000 1 1 0 00000000 0 0 0 07 00002028
0 0 00003000 02800000 02800000 02800000 02800000 4c000020 02800000 02800000 02800000 ff 1 4 00003100 1 00005550 0 0 1 00005550 1 0 1 1f 00005550
0 0 00004000 02800000 4c000001 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 3 00007000 0 00000000 0 0 0 00000000 0 0 0 03 00007000
0 0 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 df 0 0 00000000 0 00000000 0 0 0 00000000 0 0 0 3f 00000000
0 0 00001010 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 0 00001040 0 00000000 0 0 0 00000000 0 0 0 ff 00000000
0 0 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 2 00001020 0 00000000 0 0 0 00000000 1 1 0 ff 00000000
1 0 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 0 00002000 0 00000000 0 0 0 00000000 0 0 0 00 00000000
0 0 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 0 00002000 0 00000000 0 0 1 00001020 1 0 1 ff 00000000
0 1 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 0 00002000 0 00000000 0 0 0 00000000 0 0 0 00 00000000
0 0 00001000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 02800000 ff 1 0 00002000 0 00000000 0 0 1 00001020 1 0 1 ff 00000000

/* list.f */
source/preDecodePkg.sv
source/instClassify.sv
source/endSlotLocate.sv
source/targetCheck.sv
source/bundleEmit.sv
source/stageReg.sv
source/preDecodeTop.sv
verif/preDecodeCheck.sv
verif/preDecodeTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = preDecodeTb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
